//--- bios.hex
// one 32-bit rom word per line, word index 0 to 15 in order
3C081F80
35080000
3C09BFC0
8D2A0010
AD0A0000
24420001
1440FFFD
00000000
0BF00040
27BDFFE8
AFBF0014
0C0F0123
8FBF0014
03E00008
27BD0018
B105F00F

//--- filelist.f
+incdir+include
src/mem_map_pkg.sv
src/bus_pkg.sv
src/bios_rom.sv
src/scratchpad_ram.sv
src/main_ram.sv
src/mem_arbiter.sv
src/addr_decoder.sv
src/mem_controller.sv
tests/tb_mem_controller.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_mem_controller
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- include/tb_mem_model.svh
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

logic [31:0] mdl_main  [MAIN_RAM_WORDS]; // byte-lane image of main ram
logic [31:0] mdl_scpad [SCPAD_WORDS];
logic [31:0] mdl_bios  [BIOS_WORDS];     // filled from BIOS_FILE by the testbench

function automatic region_e addr_region(input logic [31:0] addr);
   logic [31:0] phys;
   phys = {3'b000, addr[28:0]}; // all mirrors fold here
   if (phys < MAIN_RAM_BASE + 32'(MAIN_RAM_WORDS * 4)) return REG_MAIN; // base is zero
   if (phys >= SCPAD_BASE && phys < SCPAD_BASE + 32'(SCPAD_WORDS * 4)) return REG_SCPAD;
   if (phys >= BIOS_BASE && phys < BIOS_BASE + 32'(BIOS_WORDS * 4)) return REG_BIOS;
   return REG_NONE;
endfunction

function automatic void apply_write(input logic [31:0] addr, input logic [31:0] wdata,
                                    input logic [3:0] ben);
   region_e r;
   r = addr_region(addr);
   for (int b = 0; b < 4; b++) begin
      if (ben[b] && r == REG_MAIN) mdl_main[addr[MAIN_AW+1:2]][8*b +: 8] = wdata[8*b +: 8];
      if (ben[b] && r == REG_SCPAD) mdl_scpad[addr[SCPAD_AW+1:2]][8*b +: 8] = wdata[8*b +: 8];
   end // rom and holes drop writes
endfunction

function automatic logic [31:0] expected_read(input logic [31:0] addr);
   case (addr_region(addr))
      REG_MAIN:  return mdl_main[addr[MAIN_AW+1:2]];
      REG_SCPAD: return mdl_scpad[addr[SCPAD_AW+1:2]];
      REG_BIOS:  return mdl_bios[addr[BIOS_AW+1:2]];
      default:   return 32'b0; // holes read zero
   endcase
endfunction

`endif

//--- tests/tb_mem_controller.sv
`timescale 1ns/1ps

module tb_mem_controller
   import mem_map_pkg::*;
   import bus_pkg::*;
();

   localparam int CLK_PERIOD      = 100;
   localparam int N_TRANS         = 400;
   localparam int N_DIRECTED      = 20;  // directed accesses ahead of the random run
   localparam int N_FILL          = MAIN_RAM_WORDS + SCPAD_WORDS; // one write per ram word
   localparam int WATCHDOG_CYCLES = (N_TRANS + N_DIRECTED + N_FILL) * 20;

   logic        clk;
   logic        rst;
   mem_req_t    data_req;
   mem_rsp_t    data_rsp;
   logic [31:0] inst_addr;
   logic        inst_ren;
   mem_rsp_t    inst_rsp;
   time         d_ack_t;   // when each port last saw ack
   time         i_ack_t;

   `include "tb_mem_model.svh"

   mem_controller u_mem_controller (
      .clk(clk), .rst(rst),
      .data_req_i(data_req), .data_rsp_o(data_rsp),
      .inst_addr_i(inst_addr), .inst_ren_i(inst_ren), .inst_rsp_o(inst_rsp));

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
      assert (got === exp) else fail_run($sformatf("MISMATCH %s exp=%h got=%h", name, exp, got));
   endtask

   // random word address in one region, through a random segment mirror
   function automatic logic [31:0] rand_addr(input int unsigned region);
      logic [2:0]  seg;
      logic [31:0] off;
      case ($urandom_range(2))
         0:       seg = 3'b000; // kuseg
         1:       seg = 3'b100; // kseg0
         default: seg = 3'b101; // kseg1
      endcase
      case (region)
         0:       off = MAIN_RAM_BASE + 32'($urandom_range(MAIN_RAM_WORDS - 1)) * 4;
         1:       off = SCPAD_BASE + 32'($urandom_range(SCPAD_WORDS - 1)) * 4;
         2:       off = BIOS_BASE + 32'($urandom_range(BIOS_WORDS - 1)) * 4;
         default: off = 32'h1F00_0000 + 32'($urandom_range(4095)) * 4; // hole below scratchpad
      endcase
      return {seg, off[28:0]};
   endfunction

   // start value of a ram word, all address bits mixed in
   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return addr ^ {addr[7:0], addr[31:8]} ^ 32'h6B3C_91E5;
   endfunction

   task automatic data_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic ren, input logic [3:0] ben);
      int n;
      @(negedge clk);
      data_req = '{addr: addr, wdata: wdata, ren: ren, ben: ben};
      do @(negedge clk); while (!data_rsp.ack);
      d_ack_t = $time;
      if (ren) check_word("data_rsp.rdata", expected_read(addr), data_rsp.rdata);
      else apply_write(addr, wdata, ben); // model updated at ack
      @(negedge clk); // keep the level one more cycle
      assert (data_rsp.ack) else fail_run("data ack fell while the request was still held");
      data_req.ren = 1'b0;
      data_req.ben = 4'b0;
      n = 0;
      while (data_rsp.ack) begin
         @(negedge clk);
         n++;
         assert (n <= 2) else fail_run("data ack did not fall after the request dropped");
      end
   endtask

   task automatic inst_fetch(input logic [31:0] addr);
      int n;
      @(negedge clk);
      inst_addr = addr;
      inst_ren  = 1'b1;
      do @(negedge clk); while (!inst_rsp.ack);
      i_ack_t = $time;
      check_word("inst_rsp.rdata", expected_read(addr), inst_rsp.rdata); // after any data write
      @(negedge clk);
      assert (inst_rsp.ack) else fail_run("inst ack fell while the request was still held");
      inst_ren = 1'b0;
      n = 0;
      while (inst_rsp.ack) begin
         @(negedge clk);
         n++;
         assert (n <= 2) else fail_run("inst ack did not fall after the request dropped");
      end
   endtask

   // every word of a ram gets a known value before any read
   task automatic fill_region(input logic [31:0] base, input int words);
      logic [31:0] a;
      for (int i = 0; i < words; i++) begin
         a = base + 32'(i) * 4;
         data_access(a, fill_word(a), 1'b0, 4'hF);
      end
   endtask

   // both ports raise on the same falling edge, data must win
   task automatic both_ports(input logic [31:0] addr, input logic [31:0] wdata, input logic ren,
                             input logic [3:0] ben, input logic [31:0] iaddr);
      fork
         data_access(addr, wdata, ren, ben);
         inst_fetch(iaddr);
      join
      assert (d_ack_t < i_ack_t) else fail_run("instruction ack came before the data ack");
   endtask

   always @(negedge clk) begin
      if (!rst) begin
         assert (!(data_rsp.ack && inst_rsp.ack))
            else fail_run("data and instruction acks were high in the same cycle");
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      fail_run("watchdog expired, the run hung waiting for a port ack");
   end

   initial begin
      logic [31:0] addr;
      logic [31:0] iaddr;
      logic [31:0] wdata;
      logic        ren;
      logic [3:0]  ben;
      void'($urandom(32'hddc5));
      $readmemh(BIOS_FILE, mdl_bios); // same image as the rom
      rst       = 1'b1;
      data_req  = '0;
      inst_addr = 32'b0;
      inst_ren  = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      assert (!data_rsp.ack && !inst_rsp.ack) else fail_run("a port ack was high after reset");

      fill_region(SCPAD_BASE, SCPAD_WORDS);
      fill_region(MAIN_RAM_BASE, MAIN_RAM_WORDS);

      data_access(SCPAD_BASE + 32'h14, 32'hCAFE_F00D, 1'b0, 4'hF); // kuseg write
      data_access(32'h8000_0000 | (SCPAD_BASE + 32'h14), 32'h1122_3344, 1'b0, 4'b0101);
      inst_fetch(32'hA000_0000 | (SCPAD_BASE + 32'h14)); // merged word via kseg1
      data_access(32'h8000_0000 | (SCPAD_BASE + 32'h14), 32'b0, 1'b1, 4'b0);
      data_access(32'h0000_0040, 32'hDEAD_BEEF, 1'b0, 4'hF); // main ram
      data_access(32'hA000_0040, 32'h7700_0000, 1'b0, 4'b1000);
      inst_fetch(32'h8000_0040);
      data_access(32'h0000_0040, 32'b0, 1'b1, 4'b0);
      data_access(32'hBFC0_0008, 32'hFFFF_FFFF, 1'b0, 4'hF); // rom write dropped
      data_access(32'hBFC0_0008, 32'b0, 1'b1, 4'b0);
      inst_fetch(32'h1FC0_0008);
      data_access(32'h0000_0008, 32'b0, 1'b1, 4'b0); // rams at the same index untouched
      data_access(SCPAD_BASE + 32'h8, 32'b0, 1'b1, 4'b0);
      data_access(32'h1F00_0100, 32'h5555_AAAA, 1'b0, 4'hF); // hole
      data_access(32'h9F00_0100, 32'b0, 1'b1, 4'b0);
      data_access(32'h0000_0100, 32'b0, 1'b1, 4'b0); // same low bits, no stray write
      data_access(SCPAD_BASE + 32'h100, 32'b0, 1'b1, 4'b0);
      both_ports(32'h0000_0080, 32'h0BAD_CAFE, 1'b0, 4'hF, 32'h0000_0080);

      for (int t = 0; t < N_TRANS; t++) begin
         addr  = rand_addr($urandom_range(3));
         iaddr = rand_addr($urandom_range(3));
         wdata = $urandom;
         ren   = 1'($urandom_range(1));
         ben   = ren ? 4'h0 : 4'($urandom_range(15, 1));
         case ($urandom_range(2))
            0:       data_access(addr, wdata, ren, ben);
            1:       inst_fetch(iaddr);
            default: both_ports(addr, wdata, ren, ben, iaddr);
         endcase
      end

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

//--- src/mem_controller.sv
`timescale 1ns/1ps

module mem_controller
   import mem_map_pkg::*;
   import bus_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  mem_req_t    data_req_i,
   output mem_rsp_t    data_rsp_o,
   input  logic [31:0] inst_addr_i,
   input  logic        inst_ren_i,
   output mem_rsp_t    inst_rsp_o
);

   mem_req_t             tgt_req;  // arbiter to decoder
   mem_rsp_t             tgt_rsp;
   logic [BIOS_AW-1:0]   bios_idx;
   logic [31:0]          bios_rdata;
   logic [SCPAD_AW-1:0]  sc_idx;
   logic                 sc_we;
   logic [31:0]          sc_rdata;
   logic [MAIN_AW-1:0]   mr_idx;
   logic                 mr_we;
   logic                 mr_ren;
   logic [31:0]          mr_rdata;
   logic                 mr_ready;
   logic [3:0]           mem_ben;  // shared by both writable memories
   logic [31:0]          mem_wdata;

   mem_arbiter u_mem_arbiter (
      .clk(clk), .rst(rst),
      .data_req_i(data_req_i), .inst_addr_i(inst_addr_i), .inst_ren_i(inst_ren_i),
      .tgt_rsp_i(tgt_rsp), .tgt_req_o(tgt_req),
      .data_rsp_o(data_rsp_o), .inst_rsp_o(inst_rsp_o));

   addr_decoder u_addr_decoder (
      .clk(clk), .rst(rst), .tgt_req_i(tgt_req), .tgt_rsp_o(tgt_rsp),
      .bios_idx_o(bios_idx), .bios_rdata_i(bios_rdata),
      .sc_idx_o(sc_idx), .sc_we_o(sc_we), .sc_rdata_i(sc_rdata),
      .mr_idx_o(mr_idx), .mr_we_o(mr_we), .mr_ren_o(mr_ren),
      .mr_rdata_i(mr_rdata), .mr_ready_i(mr_ready),
      .ben_o(mem_ben), .wdata_o(mem_wdata));

   bios_rom u_bios_rom (.clk(clk), .idx_i(bios_idx), .rdata_o(bios_rdata));

   scratchpad_ram u_scratchpad_ram (
      .clk(clk), .idx_i(sc_idx), .we_i(sc_we), .ben_i(mem_ben),
      .wdata_i(mem_wdata), .rdata_o(sc_rdata));

   main_ram u_main_ram (
      .clk(clk), .rst(rst), .idx_i(mr_idx), .we_i(mr_we), .ren_i(mr_ren),
      .ben_i(mem_ben), .wdata_i(mem_wdata), .rdata_o(mr_rdata), .ready_o(mr_ready));

endmodule

//--- src/addr_decoder.sv
`timescale 1ns/1ps

module addr_decoder
   import mem_map_pkg::*;
   import bus_pkg::*;
(
   input  logic                clk,
   input  logic                rst,
   input  mem_req_t            tgt_req_i,
   output mem_rsp_t            tgt_rsp_o,
   output logic [BIOS_AW-1:0]  bios_idx_o,
   input  logic [31:0]         bios_rdata_i,
   output logic [SCPAD_AW-1:0] sc_idx_o,
   output logic                sc_we_o,
   input  logic [31:0]         sc_rdata_i,
   output logic [MAIN_AW-1:0]  mr_idx_o,
   output logic                mr_we_o,
   output logic                mr_ren_o,
   input  logic [31:0]         mr_rdata_i,
   input  logic                mr_ready_i,
   output logic [3:0]          ben_o,
   output logic [31:0]         wdata_o
);

   logic [31:0] phys;       // segment bits stripped, mirrors alias
   region_e     region;
   logic        wr;
   logic        active;
   logic        first;      // first cycle of a request
   logic        started_q;
   logic        ack_q;
   logic [31:0] rdata;

   assign phys   = tgt_req_i.addr & SEG_MASK;
   assign wr     = |tgt_req_i.ben;
   assign active = tgt_req_i.ren | wr;
   assign first  = active & ~started_q;

   always_comb begin // unsigned wrap makes below-base addresses miss
      if (phys - MAIN_RAM_BASE < 32'(MAIN_RAM_WORDS * 4)) region = REG_MAIN;
      else if (phys - SCPAD_BASE < 32'(SCPAD_WORDS * 4)) region = REG_SCPAD;
      else if (phys - BIOS_BASE < 32'(BIOS_WORDS * 4)) region = REG_BIOS;
      else region = REG_NONE;
   end

   assign bios_idx_o = phys[BIOS_AW+1:2]; // bases aligned, low bits are offset
   assign sc_idx_o   = phys[SCPAD_AW+1:2];
   assign mr_idx_o   = phys[MAIN_AW+1:2];
   assign sc_we_o    = first & wr & (region == REG_SCPAD);
   assign mr_we_o    = first & wr & (region == REG_MAIN);
   assign mr_ren_o   = first & tgt_req_i.ren & (region == REG_MAIN);
   assign ben_o      = tgt_req_i.ben;
   assign wdata_o    = tgt_req_i.wdata;

   always_comb begin
      unique case (region)
         REG_MAIN:  rdata = mr_rdata_i;
         REG_SCPAD: rdata = sc_rdata_i;
         REG_BIOS:  rdata = bios_rdata_i;
         default:   rdata = 32'b0; // hole
      endcase
   end

   assign tgt_rsp_o = '{ack: ack_q, rdata: rdata};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         started_q <= 1'b0;
         ack_q     <= 1'b0;
      end else begin
         started_q <= active;
         if (!active) ack_q <= 1'b0; // falls once request drops
         else if (region != REG_MAIN) ack_q <= 1'b1; // block rams answer next cycle
         else if (started_q && mr_ready_i) ack_q <= 1'b1;
      end
   end

   // rom window taken straight from the address bits
   a_bios_ro: assert property (@(posedge clk) disable iff (rst)
      (wr && phys[31:BIOS_AW+2] == BIOS_BASE[31:BIOS_AW+2]) |-> !(sc_we_o || mr_we_o));

endmodule

//--- src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
   import bus_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  mem_req_t    data_req_i,
   input  logic [31:0] inst_addr_i,
   input  logic        inst_ren_i,
   input  mem_rsp_t    tgt_rsp_i,
   output mem_req_t    tgt_req_o,
   output mem_rsp_t    data_rsp_o,
   output mem_rsp_t    inst_rsp_o
);

   arb_state_e  state_q;
   logic        data_act;  // data port request level
   logic        tgt_act;   // request still shown to decoder
   logic [31:0] addr_q;
   logic [31:0] wdata_q;
   logic        ren_q;
   logic [3:0]  ben_q;
   logic        d_ack_q;
   logic        i_ack_q;
   logic [31:0] d_rdata_q; // per-port read latches
   logic [31:0] i_rdata_q;

   assign data_act   = data_req_i.ren | (|data_req_i.ben);
   assign tgt_act    = ren_q | (|ben_q);
   assign tgt_req_o  = '{addr: addr_q, wdata: wdata_q, ren: ren_q, ben: ben_q};
   assign data_rsp_o = '{ack: d_ack_q, rdata: d_rdata_q};
   assign inst_rsp_o = '{ack: i_ack_q, rdata: i_rdata_q};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q <= S_IDLE;
         ren_q   <= 1'b0;
         ben_q   <= 4'b0;
         d_ack_q <= 1'b0;
         i_ack_q <= 1'b0;
      end else begin
         unique case (state_q)
            S_IDLE: begin
               if (data_act) begin // data wins a tie
                  ren_q   <= data_req_i.ren;
                  ben_q   <= data_req_i.ren ? 4'b0 : data_req_i.ben; // read beats write
                  state_q <= data_req_i.ren ? S_RD_DATA_INIT : S_WR_INIT;
               end else if (inst_ren_i) begin
                  ren_q   <= 1'b1;
                  ben_q   <= 4'b0;
                  state_q <= S_RD_INST_INIT;
               end
            end
            S_RD_DATA_INIT, S_WR_INIT: begin
               if (tgt_rsp_i.ack) begin
                  d_ack_q <= 1'b1; // rdata latched same edge
                  state_q <= (state_q == S_WR_INIT) ? S_WR_DATA : S_RD_DATA;
               end
            end
            S_RD_INST_INIT: begin
               if (tgt_rsp_i.ack) begin
                  i_ack_q <= 1'b1;
                  state_q <= S_RD_INST;
               end
            end
            S_RD_DATA, S_WR_DATA: begin
               if (!data_act) begin // port let go, drop request and ack
                  ren_q   <= 1'b0;
                  ben_q   <= 4'b0;
                  d_ack_q <= 1'b0;
               end
               if (!tgt_act && !tgt_rsp_i.ack) state_q <= S_IDLE; // decoder idle too
            end
            S_RD_INST: begin
               if (!inst_ren_i) begin
                  ren_q   <= 1'b0;
                  i_ack_q <= 1'b0;
               end
               if (!tgt_act && !tgt_rsp_i.ack) state_q <= S_IDLE;
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == S_IDLE) begin // capture whichever port gets the grant
         addr_q  <= data_act ? data_req_i.addr : inst_addr_i;
         wdata_q <= data_req_i.wdata;
      end
      if (state_q == S_RD_DATA_INIT && tgt_rsp_i.ack) d_rdata_q <= tgt_rsp_i.rdata;
      if (state_q == S_RD_INST_INIT && tgt_rsp_i.ack) i_rdata_q <= tgt_rsp_i.rdata;
   end

   a_one_ack: assert property (@(posedge clk) disable iff (rst) !(d_ack_q && i_ack_q));

   // decoder must see a steady request until it acks
   a_req_stable: assert property (@(posedge clk) disable iff (rst)
      (tgt_act && !tgt_rsp_i.ack) |=> $stable(tgt_req_o));

endmodule

//--- src/main_ram.sv
`timescale 1ns/1ps

module main_ram
   import mem_map_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  logic [MAIN_AW-1:0] idx_i,
   input  logic               we_i,
   input  logic               ren_i,
   input  logic [3:0]         ben_i,
   input  logic [31:0]        wdata_i,
   output logic [31:0]        rdata_o,
   output logic               ready_o
);

   logic [31:0]            mem [MAIN_RAM_WORDS];
   logic [MAIN_WAIT_W-1:0] cnt_q; // cycles left until ready

   always_ff @(posedge clk) begin
      if (we_i) begin
         for (int b = 0; b < 4; b++) begin
            if (ben_i[b]) mem[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
         end
      end
      if (ren_i) rdata_o <= mem[idx_i]; // held until next read strobe
   end

   // ready pulses MAIN_RAM_WAIT cycles after the strobe
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cnt_q   <= '0;
         ready_o <= 1'b0;
      end else if (we_i || ren_i) begin
         cnt_q   <= MAIN_WAIT_W'(MAIN_RAM_WAIT - 1);
         ready_o <= (MAIN_RAM_WAIT == 1);
      end else begin
         if (cnt_q != '0) cnt_q <= cnt_q - MAIN_WAIT_W'(1);
         ready_o <= (cnt_q == MAIN_WAIT_W'(1)); // one-cycle level
      end
   end

endmodule

//--- src/scratchpad_ram.sv
`timescale 1ns/1ps

module scratchpad_ram
   import mem_map_pkg::*;
(
   input  logic                clk,
   input  logic [SCPAD_AW-1:0] idx_i,
   input  logic                we_i,
   input  logic [3:0]          ben_i,
   input  logic [31:0]         wdata_i,
   output logic [31:0]         rdata_o
);

   logic [31:0] mem [SCPAD_WORDS];

   always_ff @(posedge clk) begin
      if (we_i) begin
         for (int b = 0; b < 4; b++) begin
            if (ben_i[b]) mem[idx_i][8*b +: 8] <= wdata_i[8*b +: 8]; // lane merge
         end
      end
      rdata_o <= mem[idx_i]; // old word on a write cycle
   end

endmodule

//--- src/bios_rom.sv
`timescale 1ns/1ps

module bios_rom
   import mem_map_pkg::*;
(
   input  logic               clk,
   input  logic [BIOS_AW-1:0] idx_i,
   output logic [31:0]        rdata_o
);

   logic [31:0] rom [BIOS_WORDS];

   initial begin
      $readmemh(BIOS_FILE, rom); // image loaded at elaboration
   end

   always_ff @(posedge clk) begin
      rdata_o <= rom[idx_i]; // registered read
   end

endmodule

//--- src/bus_pkg.sv
package bus_pkg;

   // request toward memory, level held until ack
   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] wdata;
      logic        ren;  // read level
      logic [3:0]  ben;  // write byte lanes, nonzero means write
   } mem_req_t;

   typedef struct packed {
      logic        ack;
      logic [31:0] rdata;
   } mem_rsp_t;

   // one-hot arbiter states
   typedef enum logic [6:0] {
      S_IDLE         = 7'b000_0001,
      S_RD_DATA_INIT = 7'b000_0010,
      S_RD_INST_INIT = 7'b000_0100,
      S_RD_DATA      = 7'b000_1000,
      S_RD_INST      = 7'b001_0000,
      S_WR_INIT      = 7'b010_0000,
      S_WR_DATA      = 7'b100_0000
   } arb_state_e;

endpackage

//--- src/mem_map_pkg.sv
package mem_map_pkg;

   localparam logic [31:0] SEG_MASK      = 32'h1FFF_FFFF; // clears kuseg/kseg0/kseg1 bits
   localparam logic [31:0] MAIN_RAM_BASE = 32'h0000_0000;
   localparam logic [31:0] SCPAD_BASE    = 32'h1F80_0000;
   localparam logic [31:0] BIOS_BASE     = 32'h1FC0_0000;

   localparam int MAIN_RAM_WORDS = 1024; // 4 KiB stand-in for sdram
   localparam int SCPAD_WORDS    = 256;  // 1 KiB
   localparam int BIOS_WORDS     = 16;
   localparam int MAIN_RAM_WAIT  = 3;    // extra cycles before main ram ready

   localparam int MAIN_AW     = $clog2(MAIN_RAM_WORDS); // word index widths
   localparam int SCPAD_AW    = $clog2(SCPAD_WORDS);
   localparam int BIOS_AW     = $clog2(BIOS_WORDS);
   localparam int MAIN_WAIT_W = $clog2(MAIN_RAM_WAIT + 1); // wait counter width

   localparam string BIOS_FILE = "bios.hex";

   typedef enum logic [1:0] {
      REG_MAIN,  // main ram
      REG_SCPAD, // scratchpad
      REG_BIOS,  // rom, writes dropped
      REG_NONE   // hole, reads zero
   } region_e;

endpackage
